//--- tti_pkg.sv
// TTI word width, Wishbone request/response structs, byte stream struct and register map
`default_nettype none

package tti_pkg;

  localparam int unsigned TtiWordWidth = 32;

  typedef logic [TtiWordWidth-1:0] tti_word_t;

  // One byte from the bus controller, flush marks end of data
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       flush;
  } byte_stream_t;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [1:0]              adr;
    logic [TtiWordWidth-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                    ack;
    logic [TtiWordWidth-1:0] dat;
  } wb_rsp_t;

  // Word addresses
  localparam logic [1:0] AddrRxData = 2'd0;
  localparam logic [1:0] AddrCmd    = 2'd1;
  localparam logic [1:0] AddrStatus = 2'd2;

endpackage

`default_nettype wire

//--- recovery_pkg.sv
// Recovery command record, packet header size and SMBus PEC polynomial
`default_nettype none

package recovery_pkg;

  // One finished recovery packet
  typedef struct packed {
    logic [7:0]  cmd;
    logic [15:0] len;
    logic        error;
  } rec_cmd_t;

  // Command byte plus 16-bit length
  localparam int unsigned RecHdrBytes = 3;

  // CRC-8, x^8 + x^2 + x + 1
  localparam logic [7:0] PecPoly = 8'h07;

endpackage

`default_nettype wire

//--- width_converter_8to32.sv
// Byte to 32-bit word packer with flush of partial words
`default_nettype none

module width_converter_8to32
  import tti_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         reset_i,
  input  wire byte_stream_t sink_i,
  output logic              sink_ready_o,
  output logic              source_valid_o,
  output tti_word_t         source_data_o,
  input  wire logic         source_ready_i
);

  logic [2:0] cnt_q;
  logic [2:0] cnt_next;
  tti_word_t  acc_q;
  tti_word_t  acc_next;
  tti_word_t  padded;
  tti_word_t  out_q;
  logic       out_valid_q;
  logic       beat;
  logic       emit;

  // Output slot is free or being drained this cycle
  assign sink_ready_o = ~out_valid_q | source_ready_i;
  assign beat = (sink_i.valid | sink_i.flush) & sink_ready_o;

  always_comb begin
    acc_next = acc_q;
    cnt_next = cnt_q;
    if (sink_i.valid) begin
      acc_next[cnt_q*8 +: 8] = sink_i.data;
      cnt_next = cnt_q + 3'd1;
    end
    emit = (cnt_next == 3'd4) || (sink_i.flush && cnt_next != 3'd0);
    // Zero the bytes not yet filled
    for (int i = 0; i < 4; i++) begin
      padded[i*8 +: 8] = (i < cnt_next) ? acc_next[i*8 +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (source_ready_i) begin
        out_valid_q <= 1'b0;
      end
      if (beat) begin
        cnt_q <= emit ? 3'd0 : cnt_next;
        if (emit) begin
          out_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat) begin
      acc_q <= acc_next;
      if (emit) begin
        out_q <= padded;
      end
    end
  end

  assign source_valid_o = out_valid_q;
  assign source_data_o  = out_q;

endmodule

`default_nettype wire

//--- tti_fifo.sv
// Synchronous FIFO with a configurable payload type
`default_nettype none

module tti_fifo #(
  parameter int unsigned Depth = 4,
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          full_o,
  output logic          empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);

  // Overflow and underflow requests are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- recovery_pec.sv
// Running SMBus PEC (CRC-8) register
`default_nettype none

module recovery_pec
  import recovery_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire logic       clear_i,
  input  wire logic       enable_i,
  input  wire logic [7:0] data_i,
  output logic      [7:0] crc_o
);

  logic [7:0] crc_q;

  // MSB first, one shift per bit
  function automatic logic [7:0] crc_step(input logic [7:0] crc, input logic [7:0] data);
    logic [7:0] c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ((c << 1) ^ PecPoly) : (c << 1);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      crc_q <= 8'h00;
    end else if (enable_i) begin
      crc_q <= crc_step(crc_q, data_i);
    end
  end

  assign crc_o = crc_q;

endmodule

`default_nettype wire

//--- recovery_receiver.sv
// Recovery packet parser with byte steering between normal and recovery modes
`default_nettype none

module recovery_receiver
  import tti_pkg::*;
  import recovery_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         reset_i,
  input  wire logic         recovery_en_i,
  input  wire byte_stream_t ctl_rx_i,
  output logic              ctl_rx_ready_o,
  input  wire logic         bus_start_i,
  input  wire logic         bus_stop_i,
  output byte_stream_t      conv_o,
  input  wire logic         conv_ready_i,
  output logic              cmd_push_o,
  output rec_cmd_t          cmd_o
);

  typedef enum logic [2:0] {
    StCmd,
    StLenLo,
    StLenHi,
    StPayload,
    StPec,
    StDone
  } state_e;

  state_e      state_q;
  logic [7:0]  cmd_q;
  logic [15:0] len_q;
  logic [15:0] pay_left_q;
  logic [16:0] byte_cnt_q;
  logic        pec_ok_q;
  logic        flush_q;
  logic        push_q;
  rec_cmd_t    rec_q;
  logic [7:0]  crc;
  logic        rec_beat;
  logic        len_bad;

  // Header and PEC bytes never stall
  assign ctl_rx_ready_o = (recovery_en_i && state_q != StPayload) ? 1'b1 : conv_ready_i;
  assign rec_beat = recovery_en_i & ctl_rx_i.valid & ctl_rx_ready_o;

  always_comb begin
    if (!recovery_en_i) begin
      conv_o = ctl_rx_i;
    end else begin
      conv_o.valid = ctl_rx_i.valid & (state_q == StPayload);
      conv_o.data  = ctl_rx_i.data;
      conv_o.flush = flush_q;
    end
  end

  recovery_pec u_pec (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .clear_i  (bus_start_i | bus_stop_i),
    .enable_i (rec_beat & (state_q != StPec) & (state_q != StDone)),
    .data_i   (ctl_rx_i.data),
    .crc_o    (crc)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= StCmd;
      byte_cnt_q <= '0;
      pec_ok_q   <= 1'b0;
      flush_q    <= 1'b0;
      push_q     <= 1'b0;
    end else begin
      push_q <= recovery_en_i & bus_stop_i & (byte_cnt_q != '0);
      if (flush_q && conv_ready_i) begin
        flush_q <= 1'b0;
      end
      if (bus_start_i || bus_stop_i) begin
        state_q    <= StCmd;
        byte_cnt_q <= '0;
        pec_ok_q   <= 1'b0;
        if (bus_stop_i && recovery_en_i) begin
          flush_q <= 1'b1;
        end
      end else if (rec_beat) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
        case (state_q)
          StCmd:     state_q <= StLenLo;
          StLenLo:   state_q <= StLenHi;
          StLenHi:   state_q <= ({ctl_rx_i.data, len_q[7:0]} == '0) ? StPec : StPayload;
          StPayload: begin
            if (pay_left_q == 16'd1) begin
              state_q <= StPec;
            end
          end
          StPec: begin
            state_q  <= StDone;
            pec_ok_q <= (ctl_rx_i.data == crc);
          end
          default:   state_q <= StDone;
        endcase
      end
    end
  end

  // Header fields and remaining payload count
  always_ff @(posedge clk_i) begin
    if (bus_start_i) begin
      cmd_q <= '0;
      len_q <= '0;
    end else if (rec_beat) begin
      case (state_q)
        StCmd:     cmd_q <= ctl_rx_i.data;
        StLenLo:   len_q[7:0] <= ctl_rx_i.data;
        StLenHi: begin
          len_q[15:8] <= ctl_rx_i.data;
          pay_left_q  <= {ctl_rx_i.data, len_q[7:0]};
        end
        StPayload: pay_left_q <= pay_left_q - 16'd1;
        default:   ;
      endcase
    end
  end

  assign len_bad = byte_cnt_q != (17'(RecHdrBytes) + {1'b0, len_q} + 17'd1);

  always_ff @(posedge clk_i) begin
    if (bus_stop_i) begin
      rec_q.cmd   <= cmd_q;
      rec_q.len   <= len_q;
      rec_q.error <= len_bad | ~pec_ok_q;
    end
  end

  assign cmd_push_o = push_q;
  assign cmd_o      = rec_q;

endmodule

`default_nettype wire

//--- tti_wb_regs.sv
// Wishbone classic slave over RX data queue, command queue and status word
`default_nettype none

module tti_wb_regs
  import tti_pkg::*;
  import recovery_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire wb_req_t   wb_i,
  output wb_rsp_t        wb_o,
  input  wire tti_word_t data_i,
  input  wire logic      data_empty_i,
  input  wire logic      data_full_i,
  output logic           data_pop_o,
  input  wire rec_cmd_t  cmd_i,
  input  wire logic      cmd_empty_i,
  output logic           cmd_pop_o
);

  logic      ack_q;
  logic      data_pop_q;
  logic      cmd_pop_q;
  tti_word_t dat_q;
  tti_word_t rd_data;
  logic      req;
  logic      rd;

  assign req = wb_i.cyc & wb_i.stb & ~ack_q;
  assign rd  = req & ~wb_i.we;

  // Empty queues read as zero
  always_comb begin
    rd_data = '0;
    case (wb_i.adr)
      AddrRxData: begin
        if (!data_empty_i) begin
          rd_data = data_i;
        end
      end
      AddrCmd: begin
        if (!cmd_empty_i) begin
          rd_data = {cmd_i.error, 7'b0, cmd_i.len, cmd_i.cmd};
        end
      end
      AddrStatus: rd_data = {29'b0, data_full_i, cmd_empty_i, data_empty_i};
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q      <= 1'b0;
      data_pop_q <= 1'b0;
      cmd_pop_q  <= 1'b0;
    end else begin
      ack_q      <= req;
      data_pop_q <= rd & (wb_i.adr == AddrRxData) & ~data_empty_i;
      cmd_pop_q  <= rd & (wb_i.adr == AddrCmd) & ~cmd_empty_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      dat_q <= wb_i.we ? '0 : rd_data;
    end
  end

  // Pops line up with the ack cycle
  assign data_pop_o = data_pop_q;
  assign cmd_pop_o  = cmd_pop_q;

  assign wb_o.ack = ack_q;
  assign wb_o.dat = dat_q;

endmodule

`default_nettype wire

//--- recovery_handler.sv
// TTI RX path top with recovery receiver, width converter, queues and Wishbone slave
`default_nettype none

module recovery_handler
  import tti_pkg::*;
  import recovery_pkg::*;
#(
  parameter int unsigned DataDepth = 16,
  parameter int unsigned CmdDepth  = 4
) (
  input  wire logic         clk_i,
  input  wire logic         reset_i,
  input  wire logic         recovery_en_i,
  input  wire byte_stream_t ctl_rx_i,
  output logic              ctl_rx_ready_o,
  input  wire logic         ctl_bus_start_i,
  input  wire logic         ctl_bus_stop_i,
  input  wire wb_req_t      wb_i,
  output wb_rsp_t           wb_o
);

  byte_stream_t conv_byte;
  logic         conv_ready;
  logic         word_valid;
  tti_word_t    word_data;
  logic         data_ready;
  logic         data_full;
  logic         data_empty;
  tti_word_t    data_head;
  logic         data_pop;
  logic         cmd_push;
  rec_cmd_t     cmd_rec;
  rec_cmd_t     cmd_head;
  logic         cmd_empty;
  logic         cmd_pop;

  assign data_ready = ~data_full;

  recovery_receiver u_receiver (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .recovery_en_i  (recovery_en_i),
    .ctl_rx_i       (ctl_rx_i),
    .ctl_rx_ready_o (ctl_rx_ready_o),
    .bus_start_i    (ctl_bus_start_i),
    .bus_stop_i     (ctl_bus_stop_i),
    .conv_o         (conv_byte),
    .conv_ready_i   (conv_ready),
    .cmd_push_o     (cmd_push),
    .cmd_o          (cmd_rec)
  );

  width_converter_8to32 u_conv (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .sink_i         (conv_byte),
    .sink_ready_o   (conv_ready),
    .source_valid_o (word_valid),
    .source_data_o  (word_data),
    .source_ready_i (data_ready)
  );

  tti_fifo #(
    .Depth     (DataDepth),
    .payload_t (tti_word_t)
  ) u_rx_data_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (word_valid),
    .data_i  (word_data),
    .pop_i   (data_pop),
    .data_o  (data_head),
    .full_o  (data_full),
    .empty_o (data_empty)
  );

  // Records arriving while full are dropped
  tti_fifo #(
    .Depth     (CmdDepth),
    .payload_t (rec_cmd_t)
  ) u_cmd_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (cmd_push),
    .data_i  (cmd_rec),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .full_o  (),
    .empty_o (cmd_empty)
  );

  tti_wb_regs u_wb_regs (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wb_i         (wb_i),
    .wb_o         (wb_o),
    .data_i       (data_head),
    .data_empty_i (data_empty),
    .data_full_i  (data_full),
    .data_pop_o   (data_pop),
    .cmd_i        (cmd_head),
    .cmd_empty_i  (cmd_empty),
    .cmd_pop_o    (cmd_pop)
  );

endmodule

`default_nettype wire

//--- recovery_handler_assertions.sv
// Concurrent assertions on Wishbone ack and controller byte handshake, bound to recovery_handler
`default_nettype none

module recovery_handler_assertions
  import tti_pkg::*;
(
  input wire logic         clk_i,
  input wire logic         reset_i,
  input wire byte_stream_t ctl_rx_i,
  input wire logic         ctl_rx_ready_i,
  input wire wb_req_t      wb_req_i,
  input wire wb_rsp_t      wb_rsp_i
);

  int fail_count = 0;

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else begin
      fail_count++;
      $error("Wishbone ack held for more than one cycle");
    end

  ack_after_request: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
    else begin
      fail_count++;
      $error("Wishbone ack without a preceding cyc and stb");
    end

  // Stalled byte must be held
  rx_byte_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    ctl_rx_i.valid && !ctl_rx_ready_i |=> ctl_rx_i.valid && $stable(ctl_rx_i.data))
    else begin
      fail_count++;
      $error("Controller byte changed while stalled");
    end

endmodule

bind recovery_handler recovery_handler_assertions u_assertions (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .ctl_rx_i       (ctl_rx_i),
  .ctl_rx_ready_i (ctl_rx_ready_o),
  .wb_req_i       (wb_i),
  .wb_rsp_i       (wb_o)
);

`default_nettype wire

//--- tb_checker.sv
// Checker comparing each Wishbone read with its expected value, with check and error counts
`default_nettype none

module tb_checker
  import tti_pkg::*;
(
  input  wire logic      clk_i,
  input  wire wb_req_t   wb_req_i,
  input  wire wb_rsp_t   wb_rsp_i,
  input  wire tti_word_t exp_dat_i,
  input  wire logic      exp_check_i,
  output int             check_count_o,
  output int             error_count_o
);

  logic [1:0] adr_q;
  tti_word_t  exp_q;
  logic       pend_q = 1'b0;
  int         checks_q = 0;
  int         errors_q = 0;

  function automatic string reg_name(input logic [1:0] adr);
    case (adr)
      AddrRxData: return "RX data";
      AddrCmd:    return "command";
      AddrStatus: return "status";
      default:    return "unmapped";
    endcase
  endfunction

  // Latch each request, compare when its ack arrives
  always @(posedge clk_i) begin
    if (wb_rsp_i.ack && pend_q) begin
      checks_q <= checks_q + 1;
      if (wb_rsp_i.dat !== exp_q) begin
        errors_q <= errors_q + 1;
        $display("Fail at time %0t: wb_o.dat (%s) expected %h, got %h",
                 $time, reg_name(adr_q), exp_q, wb_rsp_i.dat);
      end
    end
    if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_i.ack) begin
      adr_q  <= wb_req_i.adr;
      exp_q  <= exp_dat_i;
      pend_q <= exp_check_i && !wb_req_i.we;
    end else if (wb_rsp_i.ack) begin
      pend_q <= 1'b0;
    end
  end

  assign check_count_o = checks_q;
  assign error_count_o = errors_q;

endmodule

`default_nettype wire

//--- tb_recovery_handler.sv
// Testbench top with clock, reset, stimulus tasks, LCG, reference model and watchdog
`default_nettype none

module tb_recovery_handler
  import tti_pkg::*;
();

  localparam int unsigned DataDepth = 16;
  localparam int unsigned CmdDepth  = 4;
  localparam int unsigned FillBytes = DataDepth * 4 + 8;

  logic         clk = 1'b0;
  logic         reset;
  logic         recovery_en;
  byte_stream_t ctl_rx;
  logic         ctl_rx_ready;
  logic         bus_start;
  logic         bus_stop;
  wb_req_t      wb_req;
  wb_rsp_t      wb_rsp;
  tti_word_t    exp_dat;
  logic         exp_check;
  int           check_count;
  int           error_count;
  int           tb_errors;
  int           reported_errors;
  int           total_bytes;
  logic         rdy_at_edge;
  logic [31:0]  lcg_state;
  logic [15:0]  pkt_len [2];
  logic [7:0]   payload [$];
  tti_word_t    exp_words [$];

  always #20 clk = ~clk;

  // Ready as seen by the rising edge that just passed
  always @(posedge clk) begin
    rdy_at_edge <= ctl_rx_ready;
  end

  recovery_handler #(
    .DataDepth (DataDepth),
    .CmdDepth  (CmdDepth)
  ) DUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .recovery_en_i   (recovery_en),
    .ctl_rx_i        (ctl_rx),
    .ctl_rx_ready_o  (ctl_rx_ready),
    .ctl_bus_start_i (bus_start),
    .ctl_bus_stop_i  (bus_stop),
    .wb_i            (wb_req),
    .wb_o            (wb_rsp)
  );

  tb_checker u_checker (
    .clk_i         (clk),
    .wb_req_i      (wb_req),
    .wb_rsp_i      (wb_rsp),
    .exp_dat_i     (exp_dat),
    .exp_check_i   (exp_check),
    .check_count_o (check_count),
    .error_count_o (error_count)
  );

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Compare mismatches, stimulus failures and assertion failures together
  function automatic int total_errors();
    return error_count + tb_errors + DUT.u_assertions.fail_count;
  endfunction

  // Bit-serial SMBus CRC-8 with one input bit per step
  function automatic logic [7:0] crc8_ref(input logic [7:0] crc, input logic [7:0] b);
    logic [7:0] c;
    logic       fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[7] ^ b[i];
      c = {c[6:0], 1'b0};
      if (fb) begin
        c = c ^ 8'h07;
      end
    end
    return c;
  endfunction

  // Expected words for the current payload with a zero-padded tail
  function automatic void queue_expected_words();
    tti_word_t w;
    w = '0;
    for (int i = 0; i < payload.size(); i++) begin
      w[(i % 4) * 8 +: 8] = payload[i];
      if (i % 4 == 3 || i == payload.size() - 1) begin
        exp_words.push_back(w);
        w = '0;
      end
    end
  endfunction

  function automatic tti_word_t cmd_word_ref(input logic [7:0] cmd, input logic [15:0] len,
                                             input logic err);
    tti_word_t w;
    w       = '0;
    w[7:0]  = cmd;
    w[23:8] = len;
    w[31]   = err;
    return w;
  endfunction

  task automatic fill_payload(input int n);
    payload.delete();
    for (int i = 0; i < n; i++) begin
      payload.push_back(next_rand());
    end
    queue_expected_words();
  endtask

  // One controller beat carrying a byte or a bare flush
  task automatic send_beat(input logic is_flush, input logic [7:0] b);
    @(negedge clk);
    ctl_rx.valid = ~is_flush;
    ctl_rx.flush = is_flush;
    ctl_rx.data  = b;
    do begin
      @(negedge clk);
    end while (!rdy_at_edge);
    ctl_rx.valid = 1'b0;
    ctl_rx.flush = 1'b0;
  endtask

  task automatic send_payload();
    foreach (payload[i]) begin
      send_beat(1'b0, payload[i]);
    end
  endtask

  task automatic pulse_bus(input logic is_stop);
    @(negedge clk);
    bus_start = ~is_stop;
    bus_stop  = is_stop;
    @(negedge clk);
    bus_start = 1'b0;
    bus_stop  = 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] adr, input tti_word_t exp, input logic check,
                         output tti_word_t dat);
    int waited;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    exp_dat    = exp;
    exp_check  = check;
    waited     = 0;
    dat        = '0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < 16);
    if (wb_rsp.ack) begin
      dat = wb_rsp.dat;
    end else begin
      tb_errors++;
      $display("Wishbone read of address %0d was never acknowledged", adr);
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  // Poll status until the bit reaches the value
  task automatic wait_status(input int bit_idx, input logic value);
    tti_word_t st;
    int        polls;
    polls = 0;
    do begin
      wb_read(AddrStatus, '0, 1'b0, st);
      polls++;
    end while (st[bit_idx] != value && polls < 100);
    if (st[bit_idx] != value) begin
      tb_errors++;
      $display("Status bit %0d never reached %0d", bit_idx, value);
    end
  endtask

  task automatic read_expected_words();
    tti_word_t w;
    tti_word_t d;
    while (exp_words.size() > 0) begin
      w = exp_words.pop_front();
      wait_status(0, 1'b0);
      wb_read(AddrRxData, w, 1'b1, d);
    end
  endtask

  task automatic wait_for_stall();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (rdy_at_edge && cycles < 1000);
    if (rdy_at_edge) begin
      tb_errors++;
      $display("ctl_rx_ready_o never dropped while the data queue filled");
    end
  endtask

  task automatic run_packet(input logic [15:0] len, input logic corrupt);
    logic [7:0] cmd;
    logic [7:0] crc;
    tti_word_t  d;
    cmd = next_rand();
    fill_payload(int'(len));
    crc = crc8_ref(8'h00, cmd);
    crc = crc8_ref(crc, len[7:0]);
    crc = crc8_ref(crc, len[15:8]);
    foreach (payload[i]) begin
      crc = crc8_ref(crc, payload[i]);
    end
    pulse_bus(1'b0);
    send_beat(1'b0, cmd);
    send_beat(1'b0, len[7:0]);
    send_beat(1'b0, len[15:8]);
    send_payload();
    send_beat(1'b0, corrupt ? (crc ^ 8'h5a) : crc);
    pulse_bus(1'b1);
    wait_status(1, 1'b0);
    wb_read(AddrCmd, cmd_word_ref(cmd, len, corrupt), 1'b1, d);
    read_expected_words();
  endtask

  task automatic finish_test(input string name);
    int errs;
    // Let the last ack reach the checker
    @(posedge clk);
    @(negedge clk);
    errs = total_errors();
    if (errs == reported_errors) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d error(s)", name, errs - reported_errors);
    end
    reported_errors = errs;
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", cycles);
    $display(">>> FAIL");
    $finish;
  endtask

  initial begin
    tti_word_t d;
    reset           = 1'b1;
    recovery_en     = 1'b0;
    ctl_rx          = '0;
    bus_start       = 1'b0;
    bus_stop        = 1'b0;
    wb_req          = '0;
    exp_dat         = '0;
    exp_check       = 1'b0;
    tb_errors       = 0;
    reported_errors = 0;
    lcg_state       = 32'd56356;
    pkt_len[0]      = 16'(1 + next_rand() % 12);
    pkt_len[1]      = 16'(1 + next_rand() % 12);
    total_bytes     = 12 + 5 + int'(pkt_len[0]) + 4 + int'(pkt_len[1]) + 4 + FillBytes;
    fork
      watchdog(total_bytes * 8 + 2000);
    join_none
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    fill_payload(12);
    send_payload();
    read_expected_words();
    wb_read(AddrStatus, 32'h3, 1'b1, d);
    finish_test("normal packing");

    fill_payload(5);
    send_payload();
    send_beat(1'b1, 8'h00);
    read_expected_words();
    finish_test("flush");

    @(negedge clk);
    recovery_en = 1'b1;
    run_packet(pkt_len[0], 1'b0);
    finish_test("good recovery packet");
    run_packet(pkt_len[1], 1'b1);
    finish_test("bad PEC");

    @(negedge clk);
    recovery_en = 1'b0;
    fill_payload(FillBytes);
    fork
      send_payload();
      begin
        // Full queue with a held word reads status 6
        wait_for_stall();
        wb_read(AddrStatus, 32'h6, 1'b1, d);
        read_expected_words();
      end
    join
    finish_test("back-pressure");

    wb_read(AddrRxData, '0, 1'b1, d);
    wb_read(AddrCmd, '0, 1'b1, d);
    wb_read(AddrStatus, 32'h3, 1'b1, d);
    finish_test("empty read");

    $display("Checks: %0d, errors: %0d", check_count, total_errors());
    if (total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
tti_pkg.sv
recovery_pkg.sv
width_converter_8to32.sv
tti_fifo.sv
recovery_pec.sv
recovery_receiver.sv
tti_wb_regs.sv
recovery_handler.sv
recovery_handler_assertions.sv
tb_checker.sv
tb_recovery_handler.sv
